//--- gteSatPkg.sv
package gteSatPkg;

	// Destination of one accumulator result
	typedef enum logic [2:0] {
		KIND_IR   = 3'd0, // IR1..3, colour comes along
		KIND_XY   = 3'd1, // SX or SY by index
		KIND_OTZ  = 3'd2, // Depth value
		KIND_IR0  = 3'd3, // Interpolation factor
		KIND_MAC0 = 3'd4  // Raw MAC0 check
	} resKind;

	localparam int ACC_W   = 45; // Accumulator incl. sign
	localparam int CLAMP_W = 16;
	localparam int COL_W   = 8;
	localparam int FLAG_W  = 32;

	// Per-component groups, component 1 sits on the highest bit
	localparam int FLG_MACPOS_BASE = 28; // 30..28
	localparam int FLG_MACNEG_BASE = 25; // 27..25
	localparam int FLG_IR_BASE     = 22; // 24..22
	localparam int FLG_COL_BASE    = 19; // 21..19, R..B

	localparam int FLG_OTZ     = 18;
	localparam int FLG_MAC0POS = 16;
	localparam int FLG_MAC0NEG = 15;
	localparam int FLG_SX      = 14;
	localparam int FLG_SY      = 13;
	localparam int FLG_IR0     = 12;
	localparam int FLG_ERR     = 31; // Summary bit

	// Bits 30..23 and 18..13 raise the summary
	localparam logic [FLAG_W-1:0] ERR_MASK = 32'h7F87_E000;

endpackage

//--- satFlags.sv
module satFlags (
	input  logic [gteSatPkg::ACC_W-1:0] i_value,
	output logic                        o_over,
	output logic                        o_under
);

	logic isNeg;
	logic anyOne;
	logic allOnes;

	// Bit 44 is the sign, 43..31 must all match bit 31 to fit in 32 bits
	assign isNeg   = i_value[gteSatPkg::ACC_W-1];
	assign anyOne  = |i_value[43:31];
	assign allOnes = &i_value[43:31];

	assign o_over  = ~isNeg & anyOne;   // Too big positive
	assign o_under = isNeg & ~allOnes;  // Too big negative

endmodule

//--- clampSat.sv
module clampSat #(
	parameter int INW         = 32,
	parameter int OUTW        = 16,
	parameter bit SIGNED_MODE = 1'b1 // 0 clips to 0..2^OUTW-1
) (
	input  logic [INW-1:0]  i_value,
	output logic [OUTW-1:0] o_value,
	output logic            o_negClamp,
	output logic            o_posClamp
);

	logic sign;

	assign sign = i_value[INW-1];

	generate
		if (SIGNED_MODE) begin : g_signed
			// Bits above the output sign must copy the sign
			logic [INW-OUTW-1:0] upper;

			assign upper      = i_value[INW-2:OUTW-1];
			assign o_negClamp = sign & ~(&upper);
			assign o_posClamp = ~sign & (|upper);

			always_comb begin
				if (o_negClamp) begin
					o_value = {1'b1, {(OUTW-1){1'b0}}}; // Most negative
				end else if (o_posClamp) begin
					o_value = {1'b0, {(OUTW-1){1'b1}}}; // Most positive
				end else begin
					o_value = i_value[OUTW-1:0];
				end
			end
		end else begin : g_positive
			// Positive only, any negative value goes to zero
			logic [INW-OUTW-2:0] upper;

			assign upper      = i_value[INW-2:OUTW];
			assign o_negClamp = sign;
			assign o_posClamp = ~sign & (|upper);

			always_comb begin
				if (o_negClamp) begin
					o_value = '0;
				end else if (o_posClamp) begin
					o_value = '1; // 2^OUTW-1
				end else begin
					o_value = i_value[OUTW-1:0];
				end
			end
		end
	endgenerate

endmodule

//--- clipIrColor.sv
module clipIrColor (
	input  logic [gteSatPkg::ACC_W-1:0]   i_value,
	input  logic                          i_sf,
	input  logic                          i_lm,
	input  logic                          i_fixedSf,
	output logic [gteSatPkg::CLAMP_W-1:0] o_clamp,
	output logic [gteSatPkg::COL_W-1:0]   o_color,
	output logic                          o_irSat,
	output logic                          o_colSat
);

	logic [31:0] postSf; // MAC view after optional >>12
	logic [15:0] irSigned;
	logic [14:0] irPos;
	logic        sNeg;
	logic        sPos;
	logic        pNeg;
	logic        pPos;
	logic        colNeg;
	logic        colPos;
	logic        fixedUnder;
	logic        fixedOver;
	logic        selSat;

	assign postSf = i_sf ? i_value[43:12] : i_value[31:0];

	// -8000h..7FFFh
	clampSat #(.INW(32), .OUTW(16), .SIGNED_MODE(1'b1)) u_irSigned (
		.i_value   (postSf),
		.o_value   (irSigned),
		.o_negClamp(sNeg),
		.o_posClamp(sPos)
	);

	// 0..7FFFh under lm
	clampSat #(.INW(32), .OUTW(15), .SIGNED_MODE(1'b0)) u_irPos (
		.i_value   (postSf),
		.o_value   (irPos),
		.o_negClamp(pNeg),
		.o_posClamp(pPos)
	);

	// Colour is value/16 clipped to one byte
	clampSat #(.INW(28), .OUTW(8), .SIGNED_MODE(1'b0)) u_color (
		.i_value   (postSf[31:4]),
		.o_value   (o_color),
		.o_negClamp(colNeg),
		.o_posClamp(colPos)
	);

	assign o_clamp = i_lm ? {1'b0, irPos} : irSigned;

	// Fixed path checks value>>12 against the signed range and ignores lm
	assign fixedUnder = i_value[43] & ~(&i_value[42:27]);
	assign fixedOver  = ~i_value[43] & (|i_value[42:27]);

	assign selSat   = i_lm ? (pNeg | pPos) : (sNeg | sPos); // lm flags every negative
	assign o_irSat  = i_fixedSf ? (fixedUnder | fixedOver) : selSat;
	assign o_colSat = colNeg | colPos;

endmodule

//--- clipXy.sv
module clipXy (
	input  logic [16:0]                   i_value,
	input  logic                          i_ovf32,
	input  logic                          i_unf32,
	output logic [gteSatPkg::CLAMP_W-1:0] o_clamp,
	output logic                          o_sat
);

	logic isNeg;
	logic isOver;
	logic isUnder;

	assign isNeg = i_value[16];

	always_comb begin
		if (i_ovf32) begin
			isOver  = 1'b1; // Wrapped value is meaningless
			isUnder = 1'b0;
		end else if (i_unf32) begin
			isOver  = 1'b0;
			isUnder = 1'b1;
		end else begin
			isOver  = ~isNeg & (|i_value[15:10]);  // Above 3FFh
			isUnder = isNeg & ~(&i_value[15:10]);  // Below -400h
		end
	end

	always_comb begin
		if (isOver) begin
			o_clamp = 16'h03FF;
		end else if (isUnder) begin
			o_clamp = 16'hFC00;
		end else begin
			o_clamp = {{6{isNeg}}, i_value[9:0]}; // In range, sign extend
		end
	end

	assign o_sat = isOver | isUnder;

endmodule

//--- clipOtz.sv
module clipOtz (
	input  logic [20:0] i_value,
	input  logic        i_ovf32,
	input  logic        i_unf32,
	output logic [15:0] o_otz,
	output logic        o_otzSat,
	output logic [15:0] o_ir0,
	output logic        o_ir0Sat
);

	logic isNeg;
	logic otzOver;
	logic ir0Over;
	logic under;

	assign isNeg = i_value[20];

	// Underflow and sign give the same lower bound for both
	assign under = ~i_ovf32 & (i_unf32 | isNeg);

	// 32-bit overflow wins over the local range checks
	assign otzOver = i_ovf32 | (~i_unf32 & ~isNeg & (|i_value[19:16]));
	assign ir0Over = i_ovf32 | (~i_unf32 & ~isNeg & (i_value[19:0] > 20'h01000));

	always_comb begin
		if (under) begin
			o_otz = 16'h0000;
		end else if (otzOver) begin
			o_otz = 16'hFFFF;
		end else begin
			o_otz = i_value[15:0];
		end
	end

	always_comb begin
		if (under) begin
			o_ir0 = 16'h0000;
		end else if (ir0Over) begin
			o_ir0 = 16'h1000; // 1.0 in 4.12
		end else begin
			o_ir0 = {3'b000, i_value[12:0]};
		end
	end

	assign o_otzSat = under | otzOver;
	assign o_ir0Sat = under | ir0Over;

endmodule

//--- satStage.sv
module satStage #(
	parameter int CREDITS = 4
) (
	input  logic                          i_clk,
	input  logic                          i_rst,
	input  logic                          i_valid,
	input  gteSatPkg::resKind             i_kind,
	input  logic [1:0]                    i_index,
	input  logic [gteSatPkg::CLAMP_W-1:0] i_clamp,
	input  logic [gteSatPkg::COL_W-1:0]   i_color,
	input  logic [gteSatPkg::FLAG_W-1:0]  i_flag,
	input  logic                          i_credit,
	output logic                          o_creditRet,
	output logic                          o_valid,
	output gteSatPkg::resKind             o_kind,
	output logic [1:0]                    o_index,
	output logic [gteSatPkg::CLAMP_W-1:0] o_clamp,
	output logic [gteSatPkg::COL_W-1:0]   o_color,
	output logic [gteSatPkg::FLAG_W-1:0]  o_flag
);

	localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;
	localparam int CNT_W = $clog2(CREDITS + 1);
	localparam int OCR_W = 8; // Output credits held at once

	gteSatPkg::resKind             kindMem  [CREDITS];
	logic [1:0]                    indexMem [CREDITS];
	logic [gteSatPkg::CLAMP_W-1:0] clampMem [CREDITS];
	logic [gteSatPkg::COL_W-1:0]   colorMem [CREDITS];
	logic [gteSatPkg::FLAG_W-1:0]  flagMem  [CREDITS];

	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;      // Entries in queue
	logic [OCR_W-1:0] outCredits; // Granted, not yet used
	logic             full;
	logic             pop;

	function automatic logic [PTR_W-1:0] ptrInc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(CREDITS - 1)) ? '0 : p + 1'b1; // Wrap for any depth
	endfunction

	assign full        = (count == CNT_W'(CREDITS));
	assign o_valid     = (count != '0) && (outCredits != '0);
	assign pop         = o_valid;
	assign o_creditRet = pop; // Slot freed this cycle

	always_ff @(posedge i_clk) begin
		if (i_valid) begin
			kindMem[wrPtr]  <= i_kind;
			indexMem[wrPtr] <= i_index;
			clampMem[wrPtr] <= i_clamp;
			colorMem[wrPtr] <= i_color;
			flagMem[wrPtr]  <= i_flag; // Word incl. this result
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			wrPtr      <= '0;
			rdPtr      <= '0;
			count      <= '0;
			outCredits <= '0;
		end else begin
			if (i_valid) begin
				wrPtr <= ptrInc(wrPtr);
			end
			if (pop) begin
				rdPtr <= ptrInc(rdPtr);
			end
			count      <= count + CNT_W'(i_valid) - CNT_W'(pop);
			outCredits <= outCredits + OCR_W'(i_credit) - OCR_W'(pop);
		end
	end

	// Head entry
	assign o_kind  = kindMem[rdPtr];
	assign o_index = indexMem[rdPtr];
	assign o_clamp = clampMem[rdPtr];
	assign o_color = colorMem[rdPtr];
	assign o_flag  = flagMem[rdPtr];

	// Upstream sent without a credit
	aWriteFull : assert property (@(posedge i_clk) disable iff (i_rst) i_valid |-> !full);

	aCreditMax : assert property (@(posedge i_clk) disable iff (i_rst)
		(i_credit && !o_valid) |-> outCredits != '1); // Downstream over-granted

endmodule

//--- flagAccum.sv
module flagAccum (
	input  logic                         i_clk,
	input  logic                         i_rst,
	input  logic                         i_load,
	input  logic                         i_first,
	input  gteSatPkg::resKind            i_kind,
	input  logic [1:0]                   i_index,
	input  logic                         i_macOvf,
	input  logic                         i_macUnf,
	input  logic                         i_irSat,
	input  logic                         i_colSat,
	input  logic                         i_xySat,
	input  logic                         i_otzSat,
	input  logic                         i_ir0Sat,
	output logic [gteSatPkg::FLAG_W-1:0] o_flag
);

	logic [gteSatPkg::FLAG_W-1:0] word;
	logic [gteSatPkg::FLAG_W-1:0] newBits;
	logic [gteSatPkg::FLAG_W-1:0] nextWord;
	logic [1:0]                   comp; // Component 1 maps to the top bit of a group

	assign comp = 2'd3 - i_index;

	always_comb begin
		newBits = '0;
		case (i_kind)
			gteSatPkg::KIND_IR: begin
				if (i_index != 2'd0) begin // Index 0 has no IR slot
					newBits[gteSatPkg::FLG_MACPOS_BASE + comp] = i_macOvf;
					newBits[gteSatPkg::FLG_MACNEG_BASE + comp] = i_macUnf;
					newBits[gteSatPkg::FLG_IR_BASE + comp]     = i_irSat;
					newBits[gteSatPkg::FLG_COL_BASE + comp]    = i_colSat;
				end
			end
			gteSatPkg::KIND_XY: begin
				if (i_index == 2'd0) begin
					newBits[gteSatPkg::FLG_SX] = i_xySat;
				end else begin
					newBits[gteSatPkg::FLG_SY] = i_xySat;
				end
			end
			gteSatPkg::KIND_OTZ: newBits[gteSatPkg::FLG_OTZ] = i_otzSat;
			gteSatPkg::KIND_IR0: newBits[gteSatPkg::FLG_IR0] = i_ir0Sat;
			gteSatPkg::KIND_MAC0: begin
				newBits[gteSatPkg::FLG_MAC0POS] = i_macOvf;
				newBits[gteSatPkg::FLG_MAC0NEG] = i_macUnf;
			end
			default: newBits = '0;
		endcase
	end

	always_comb begin
		nextWord = word;
		if (i_load) begin
			nextWord = (i_first ? '0 : word) | newBits; // New command starts clean
			nextWord[gteSatPkg::FLG_ERR] = |(nextWord & gteSatPkg::ERR_MASK);
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			word <= '0;
		end else begin
			word <= nextWord;
		end
	end

	assign o_flag = nextWord; // Value the register takes at this edge

endmodule

//--- gteSatTop.sv
module gteSatTop #(
	parameter int CREDITS = 4
) (
	input  logic                          i_clk,
	input  logic                          i_rst,
	input  logic                          i_valid,
	input  logic [gteSatPkg::ACC_W-1:0]   i_value,
	input  gteSatPkg::resKind             i_kind,
	input  logic [1:0]                    i_index,
	input  logic                          i_sf,
	input  logic                          i_lm,
	input  logic                          i_fixedSf,
	input  logic                          i_first,
	output logic                          o_creditRet,
	input  logic                          i_credit,
	output logic                          o_valid,
	output gteSatPkg::resKind             o_kind,
	output logic [1:0]                    o_index,
	output logic [gteSatPkg::CLAMP_W-1:0] o_clamp,
	output logic [gteSatPkg::COL_W-1:0]   o_color,
	output logic [gteSatPkg::FLAG_W-1:0]  o_flag
);

	logic                          macOvf;
	logic                          macUnf;
	logic [gteSatPkg::CLAMP_W-1:0] irClamp;
	logic [gteSatPkg::COL_W-1:0]   color;
	logic                          irSat;
	logic                          colSat;
	logic [gteSatPkg::CLAMP_W-1:0] xyClamp;
	logic                          xySat;
	logic [15:0]                   otz;
	logic                          otzSat;
	logic [15:0]                   ir0;
	logic                          ir0Sat;
	logic [gteSatPkg::CLAMP_W-1:0] clampSel;
	logic [gteSatPkg::FLAG_W-1:0]  flagWord;

	satFlags u_satFlags (.i_value(i_value), .o_over(macOvf), .o_under(macUnf));

	clipIrColor u_clipIrColor (
		.i_value  (i_value),
		.i_sf     (i_sf),
		.i_lm     (i_lm),
		.i_fixedSf(i_fixedSf),
		.o_clamp  (irClamp),
		.o_color  (color),
		.o_irSat  (irSat),
		.o_colSat (colSat)
	);

	// value>>16, exact while the value fits 32 bits
	clipXy u_clipXy (
		.i_value(i_value[32:16]),
		.i_ovf32(macOvf),
		.i_unf32(macUnf),
		.o_clamp(xyClamp),
		.o_sat  (xySat)
	);

	// value>>12 feeds depth and IR0
	clipOtz u_clipOtz (
		.i_value (i_value[32:12]),
		.i_ovf32 (macOvf),
		.i_unf32 (macUnf),
		.o_otz   (otz),
		.o_otzSat(otzSat),
		.o_ir0   (ir0),
		.o_ir0Sat(ir0Sat)
	);

	always_comb begin
		case (i_kind)
			gteSatPkg::KIND_IR:  clampSel = irClamp;
			gteSatPkg::KIND_XY:  clampSel = xyClamp;
			gteSatPkg::KIND_OTZ: clampSel = otz;
			gteSatPkg::KIND_IR0: clampSel = ir0;
			default:             clampSel = i_value[15:0]; // MAC0 low half
		endcase
	end

	flagAccum u_flagAccum (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_load  (i_valid),
		.i_first (i_first),
		.i_kind  (i_kind),
		.i_index (i_index),
		.i_macOvf(macOvf),
		.i_macUnf(macUnf),
		.i_irSat (irSat),
		.i_colSat(colSat),
		.i_xySat (xySat),
		.i_otzSat(otzSat),
		.i_ir0Sat(ir0Sat),
		.o_flag  (flagWord)
	);

	satStage #(.CREDITS(CREDITS)) u_satStage (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_valid    (i_valid),
		.i_kind     (i_kind),
		.i_index    (i_index),
		.i_clamp    (clampSel),
		.i_color    (color),
		.i_flag     (flagWord),
		.i_credit   (i_credit),
		.o_creditRet(o_creditRet),
		.o_valid    (o_valid),
		.o_kind     (o_kind),
		.o_index    (o_index),
		.o_clamp    (o_clamp),
		.o_color    (o_color),
		.o_flag     (o_flag)
	);

endmodule

//--- tbGteSat.sv
module tbGteSat;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CREDITS     = 4;
	localparam int N_ITEMS     = 60; // Items per behavior
	localparam int N_PHASES    = 5;
	localparam int CYCLE_LIMIT = 10 * N_ITEMS * N_PHASES + 200;

	localparam longint MAC_MAX = 64'sh0000_0000_7FFF_FFFF; // 32-bit MAC range
	localparam longint MAC_MIN = -64'sh0000_0000_8000_0000;

	logic                          clk;
	logic                          i_rst;
	logic                          i_valid;
	logic [gteSatPkg::ACC_W-1:0]   i_value;
	gteSatPkg::resKind             i_kind;
	logic [1:0]                    i_index;
	logic                          i_sf;
	logic                          i_lm;
	logic                          i_fixedSf;
	logic                          i_first;
	logic                          i_credit;
	logic                          o_creditRet;
	logic                          o_valid;
	gteSatPkg::resKind             o_kind;
	logic [1:0]                    o_index;
	logic [gteSatPkg::CLAMP_W-1:0] o_clamp;
	logic [gteSatPkg::COL_W-1:0]   o_color;
	logic [gteSatPkg::FLAG_W-1:0]  o_flag;

	// Expected outputs in issue order
	logic [gteSatPkg::CLAMP_W-1:0] expClamp [$];
	logic [gteSatPkg::COL_W-1:0]   expColor [$];
	logic [gteSatPkg::FLAG_W-1:0]  expFlag  [$];
	gteSatPkg::resKind             expKind  [$];
	logic [1:0]                    expIndex [$];

	logic [gteSatPkg::FLAG_W-1:0] flagModel = '0; // Sticky word as the model sees it
	int     errors     = 0;
	int     checks     = 0;
	int     issued     = 0;
	int     received   = 0;
	int     upCredits  = CREDITS; // Upstream side of the credit loop
	int     grantAvail = 0;       // Downstream grants not yet used
	int     comboCnt   = 0;
	int     cycles     = 0;
	longint edgeTab [11] = '{64'sh0, 64'sh7FFF, -64'sh8000, 64'shFF, 64'sh3FF, -64'sh400,
		64'shFFFF, 64'sh1000, 64'sh7FFF_FFFF, -64'sh8000_0000, 64'sh7F_FFFF_FFFF};

	gteSatTop #(.CREDITS(CREDITS)) u_dut (
		.i_clk      (clk),
		.i_rst      (i_rst),
		.i_valid    (i_valid),
		.i_value    (i_value),
		.i_kind     (i_kind),
		.i_index    (i_index),
		.i_sf       (i_sf),
		.i_lm       (i_lm),
		.i_fixedSf  (i_fixedSf),
		.i_first    (i_first),
		.o_creditRet(o_creditRet),
		.i_credit   (i_credit),
		.o_valid    (o_valid),
		.o_kind     (o_kind),
		.o_index    (o_index),
		.o_clamp    (o_clamp),
		.o_color    (o_color),
		.o_flag     (o_flag)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	// Hard stop in case the credit loop stalls
	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: outputs did not drain within %0d cycles", CYCLE_LIMIT);
			$display("test failed");
			$finish;
		end
	end

	function automatic longint clip(input longint v, input longint lo, input longint hi);
		return (v < lo) ? lo : ((v > hi) ? hi : v);
	endfunction

	// Range edges at a random scale, plus some plain noise
	function automatic logic [gteSatPkg::ACC_W-1:0] randValue();
		longint base;
		longint v;
		int     sh;
		if ($urandom_range(0, 7) == 0) begin
			return gteSatPkg::ACC_W'({$urandom, $urandom});
		end
		base = edgeTab[$urandom_range(0, 10)];
		case ($urandom_range(0, 3))
			0:       sh = 0;
			1:       sh = 4;  // Colour step
			2:       sh = 12; // sf and depth
			default: sh = 16; // Screen XY
		endcase
		v = (base + longint'($urandom_range(0, 7)) - 4) <<< sh;
		v = v + longint'($urandom_range(0, (1 << sh) - 1)); // Random fraction bits
		return v[gteSatPkg::ACC_W-1:0];
	endfunction

	task automatic compareClamp(input string name, input logic [gteSatPkg::CLAMP_W-1:0] got,
			input logic [gteSatPkg::CLAMP_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic compareColor(input string name, input logic [gteSatPkg::COL_W-1:0] got,
			input logic [gteSatPkg::COL_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic compareFlag(input string name, input logic [gteSatPkg::FLAG_W-1:0] got,
			input logic [gteSatPkg::FLAG_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic compareKind(input string name, input gteSatPkg::resKind got,
			input gteSatPkg::resKind exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic compareIndex(input string name, input logic [1:0] got, input logic [1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// Reference model, one result in, one queue entry out
	task automatic predict(input logic [gteSatPkg::ACC_W-1:0] value, input gteSatPkg::resKind kind,
			input logic [1:0] index, input logic sf, input logic lm, input logic fx,
			input logic first);
		longint sv;
		longint ps;
		longint fs;
		longint lo;
		longint irVal;
		longint col;
		longint raw;
		longint res;
		logic   over;
		logic   under;
		logic   irSat;
		logic   colSat;
		logic   sat;
		int     slot;
		logic [gteSatPkg::FLAG_W-1:0] bits;
		sv    = {{(64 - gteSatPkg::ACC_W){value[gteSatPkg::ACC_W-1]}}, value};
		over  = sv > MAC_MAX;
		under = sv < MAC_MIN;
		ps    = longint'(int'(sf ? (sv >>> 12) : sv)); // MAC register view
		fs    = longint'(int'(sv >>> 12));             // Always shifted
		lo    = lm ? 64'sh0 : -64'sh8000;
		irVal = clip(ps, lo, 64'sh7FFF);
		irSat = fx ? (fs != clip(fs, -64'sh8000, 64'sh7FFF)) : (ps != irVal);
		col    = clip(ps >>> 4, 0, 255);
		colSat = (ps >>> 4) != col;
		raw   = 0;
		sat   = 1'b0;
		bits  = '0;
		slot  = 3 - int'(index); // IR1 on the high bit
		case (kind)
			gteSatPkg::KIND_IR: begin
				res = irVal;
				if (index != 2'd0) begin
					bits[gteSatPkg::FLG_MACPOS_BASE + slot] = over;
					bits[gteSatPkg::FLG_MACNEG_BASE + slot] = under;
					bits[gteSatPkg::FLG_IR_BASE + slot]     = irSat;
					bits[gteSatPkg::FLG_COL_BASE + slot]    = colSat;
				end
			end
			gteSatPkg::KIND_XY: begin
				raw = sv >>> 16;
				res = over ? 64'sh3FF : (under ? -64'sh400 : clip(raw, -64'sh400, 64'sh3FF));
				sat = over | under | (raw != res);
				bits[(index == 2'd0) ? gteSatPkg::FLG_SX : gteSatPkg::FLG_SY] = sat;
			end
			gteSatPkg::KIND_OTZ: begin
				raw = sv >>> 12;
				res = over ? 64'shFFFF : (under ? 64'sh0 : clip(raw, 0, 64'shFFFF));
				bits[gteSatPkg::FLG_OTZ] = over | under | (raw != res);
			end
			gteSatPkg::KIND_IR0: begin
				raw = sv >>> 12;
				res = over ? 64'sh1000 : (under ? 64'sh0 : clip(raw, 0, 64'sh1000));
				bits[gteSatPkg::FLG_IR0] = over | under | (raw != res);
			end
			default: begin
				res = sv; // MAC0 passes its low half
				bits[gteSatPkg::FLG_MAC0POS] = over;
				bits[gteSatPkg::FLG_MAC0NEG] = under;
			end
		endcase
		if (first) begin
			flagModel = '0;
		end
		flagModel = flagModel | bits;
		flagModel[gteSatPkg::FLG_ERR] = |(flagModel & gteSatPkg::ERR_MASK);
		expClamp.push_back(gteSatPkg::CLAMP_W'(res));
		expColor.push_back(gteSatPkg::COL_W'(col));
		expFlag.push_back(flagModel);
		expKind.push_back(kind);
		expIndex.push_back(index);
	endtask

	// Pick and drive one result, stimulus leaning on the behavior under test
	task automatic sendItem(input int phase);
		logic [gteSatPkg::ACC_W-1:0] value;
		gteSatPkg::resKind           kind;
		logic [1:0]                  index;
		logic                        sf;
		logic                        lm;
		logic                        fx;
		logic                        first;
		value = randValue();
		sf    = 1'($urandom_range(0, 1));
		lm    = 1'($urandom_range(0, 1));
		fx    = ($urandom_range(0, 3) == 0);
		case (phase)
			1: begin
				kind = gteSatPkg::KIND_IR;
				{sf, lm, fx} = 3'(comboCnt); // Walk all eight modes
				comboCnt++;
			end
			2: begin
				kind = gteSatPkg::KIND_IR;
				fx   = 1'b0;
			end
			3:       kind = gteSatPkg::resKind'(3'($urandom_range(1, 4))); // No IR
			default: kind = gteSatPkg::resKind'(3'($urandom_range(0, 4)));
		endcase
		index = (kind == gteSatPkg::KIND_IR) ? 2'($urandom_range(1, 3)) : 2'($urandom_range(0, 3));
		first = (issued == 0) || ($urandom_range(0, (phase == 4) ? 2 : 7) == 0);
		i_valid   = 1'b1;
		i_value   = value;
		i_kind    = kind;
		i_index   = index;
		i_sf      = sf;
		i_lm      = lm;
		i_fixedSf = fx;
		i_first   = first;
		predict(value, kind, index, sf, lm, fx, first);
	endtask

	// Outputs only move on the rising edge, so the falling edge sees them settled
	task automatic checkOutputs();
		if (o_valid === 1'b1) begin
			if (expKind.size() == 0) begin
				errors++;
				$display("Output valid with no item outstanding");
			end else begin
				compareKind("o_kind", o_kind, expKind.pop_front());
				compareIndex("o_index", o_index, expIndex.pop_front());
				compareClamp("o_clamp", o_clamp, expClamp.pop_front());
				compareColor("o_color", o_color, expColor.pop_front());
				compareFlag("o_flag", o_flag, expFlag.pop_front());
			end
			if (grantAvail == 0) begin
				errors++;
				$display("Output valid without a downstream credit");
			end else begin
				grantAvail--;
			end
			received++;
		end
		if (o_creditRet !== o_valid) begin
			errors++;
			$display("Credit return does not match the output handshake");
		end
	endtask

	task automatic runPhase(input int phase, input string title, input int grantPct);
		int sent;
		int errStart;
		int recvStart;
		sent      = 0;
		errStart  = errors;
		recvStart = received;
		while (sent < N_ITEMS || expKind.size() != 0) begin
			@(negedge clk);
			checkOutputs();
			if (sent < N_ITEMS && upCredits > 0 && $urandom_range(0, 3) != 0) begin
				sendItem(phase);
				sent++;
				upCredits--;
				issued++;
				if (issued - received > CREDITS) begin
					errors++;
					$display("More than %0d items outstanding", CREDITS);
				end
			end else begin
				i_valid = 1'b0;
				i_first = 1'b0;
			end
			if (o_creditRet === 1'b1) begin
				upCredits++; // Usable from the next cycle on
			end
			i_credit = (grantAvail < 6) && ($urandom_range(0, 99) < grantPct);
			if (i_credit) begin
				grantAvail++;
			end
		end
		$display("Behavior %0d %s: %0d items, %0d errors", phase, title,
			received - recvStart, errors - errStart);
	endtask

	initial begin
		void'($urandom(32'h8532_3114));
		i_rst     = 1'b1;
		i_valid   = 1'b0;
		i_value   = '0;
		i_kind    = gteSatPkg::KIND_IR;
		i_index   = 2'd0;
		i_sf      = 1'b0;
		i_lm      = 1'b0;
		i_fixedSf = 1'b0;
		i_first   = 1'b0;
		i_credit  = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		i_rst = 1'b0;

		runPhase(1, "IR clamp sf lm fixed shift", 80);
		runPhase(2, "colour clamp", 80);
		runPhase(3, "XY OTZ IR0 MAC0 clamp", 80);
		runPhase(4, "flag stickiness", 70);
		runPhase(5, "credit flow under back-pressure", 25); // Sparse grants

		$display("Done: %0d items, %0d checks, %0d errors", received, checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- gteSat.f
gteSatPkg.sv
satFlags.sv
clampSat.sv
clipIrColor.sv
clipXy.sv
clipOtz.sv
satStage.sv
flagAccum.sv
gteSatTop.sv
tbGteSat.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the pass line shows up
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tbGteSat \
	-f gteSat.f -o simGteSat

out=$(./obj_dir/simGteSat || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'test passed'
